//--- hdl/opStream_defines.svh
`ifndef OPSTREAM_DEFINES_SVH
`define OPSTREAM_DEFINES_SVH

// 6502 bus widths
`define ADDR_W 16
`define DATA_W 8

// numeric field width of one trace record word
`define TRACE_W 32

// opcode byte plus up to two operand bytes
`define MAX_INS_BYTES 3

`endif

//--- hdl/typepkg.sv
`include "opStream_defines.svh"

package typepkg;

	typedef logic [`ADDR_W-1:0] addr_t;   // memory address or PC
	typedef logic [`DATA_W-1:0] byte_t;   // memory byte or index register
	typedef logic [1:0] insLen_t;         // 1 to 3 bytes

	// legal and undocumented mnemonics, alphabetical
	typedef enum logic [6:0]
	{
		ADC, AHX, ALR, ANC, AND, ARR, ASL, AXS,
		BCC, BCS, BEQ, BIT, BMI, BNE, BPL, BRK,
		BVC, BVS, CLC, CLD, CLI, CLV, CMP, CPX,
		CPY, DCP, DEC, DEX, DEY, EOR, INC, INX,
		INY, ISC, JMP, JSR, KIL, LAS, LAX, LDA,
		LDX, LDY, LSR, NOP, ORA, PHA, PHP, PLA,
		PLP, RLA, ROL, ROR, RRA, RTI, RTS, SAX,
		SBC, SEC, SED, SEI, SHX, SHY, SLO, SRE,
		STA, STX, STY, TAS, TAX, TAY, TSX, TXA,
		TXS, TYA, XAA
	} Opcode;

	typedef enum logic [3:0]
	{
		Imp,   // implied or accumulator
		Imm,
		Ind,   // jmp (abs) only
		IzX,
		IzY,
		Zp,
		ZpX,
		ZpY,
		Abs,
		AbX,
		AbY,
		Rel    // branches
	} Addressing;

	typedef enum logic [1:0]
	{
		Idle,
		Lead,      // first read issued, no data back yet
		Collect,   // one byte returns per cycle
		Halted     // stopped on KIL
	} fetchState_t;

endpackage

//--- hdl/insBus.sv
`timescale 1ns/1ps

interface insBus import typepkg::*; ();

	logic valid;        // one-cycle pulse per instruction
	addr_t pc;          // address of the opcode byte
	Opcode opcode;
	Addressing mode;
	insLen_t len;
	addr_t operand;     // little-endian, high byte zero when len is 2

	modport source
	(
		output valid, pc, opcode, mode, len, operand
	);

	modport sink
	(
		input valid, pc, opcode, mode, len, operand
	);

endinterface

//--- hdl/idec.sv
`timescale 1ns/1ps

module idec import typepkg::*;
(
	input logic [7:0] ins,
	output Opcode opcode,
	output Addressing mode,
	output logic [1:0] pc_bytes
);

localparam Opcode opTable [256] = '{
	BRK, ORA, KIL, SLO, NOP, ORA, ASL, SLO, PHP, ORA, ASL, ANC, NOP, ORA, ASL, SLO,  // 0x
	BPL, ORA, KIL, SLO, NOP, ORA, ASL, SLO, CLC, ORA, NOP, SLO, NOP, ORA, ASL, SLO,  // 1x
	JSR, AND, KIL, RLA, BIT, AND, ROL, RLA, PLP, AND, ROL, ANC, BIT, AND, ROL, RLA,  // 2x
	BMI, AND, KIL, RLA, NOP, AND, ROL, RLA, SEC, AND, NOP, RLA, NOP, AND, ROL, RLA,  // 3x
	RTI, EOR, KIL, SRE, NOP, EOR, LSR, SRE, PHA, EOR, LSR, ALR, JMP, EOR, LSR, SRE,  // 4x
	BVC, EOR, KIL, SRE, NOP, EOR, LSR, SRE, CLI, EOR, NOP, SRE, NOP, EOR, LSR, SRE,  // 5x
	RTS, ADC, KIL, RRA, NOP, ADC, ROR, RRA, PLA, ADC, ROR, ARR, JMP, ADC, ROR, RRA,  // 6x
	BVS, ADC, KIL, RRA, NOP, ADC, ROR, RRA, SEI, ADC, NOP, RRA, NOP, ADC, ROR, RRA,  // 7x
	NOP, STA, NOP, SAX, STY, STA, STX, SAX, DEY, NOP, TXA, XAA, STY, STA, STX, SAX,  // 8x
	BCC, STA, KIL, AHX, STY, STA, STX, SAX, TYA, STA, TXS, TAS, SHY, STA, SHX, AHX,  // 9x
	LDY, LDA, LDX, LAX, LDY, LDA, LDX, LAX, TAY, LDA, TAX, LAX, LDY, LDA, LDX, LAX,  // ax
	BCS, LDA, KIL, LAX, LDY, LDA, LDX, LAX, CLV, LDA, TSX, LAS, LDY, LDA, LDX, LAX,  // bx
	CPY, CMP, NOP, DCP, CPY, CMP, DEC, DCP, INY, CMP, DEX, AXS, CPY, CMP, DEC, DCP,  // cx
	BNE, CMP, KIL, DCP, NOP, CMP, DEC, DCP, CLD, CMP, NOP, DCP, NOP, CMP, DEC, DCP,  // dx
	CPX, SBC, NOP, ISC, CPX, SBC, INC, ISC, INX, SBC, NOP, SBC, CPX, SBC, INC, ISC,  // ex
	BEQ, SBC, KIL, ISC, NOP, SBC, INC, ISC, SED, SBC, NOP, ISC, NOP, SBC, INC, ISC   // fx
};

logic oddRow;     // indexed and relative half of the map
logic yIndexed;   // 9x/bx rows index X-register ops by Y

assign opcode = opTable[ins];
assign oddRow = ins[4];
assign yIndexed = (ins[7:6] == 2'b10);

// mode follows the low nibble, with a few row exceptions
always_comb
begin
	mode = Imp;
	case (ins[3:0])
	4'h0: mode = oddRow ? Rel : ((ins == 8'h20) ? Abs : (ins[7] ? Imm : Imp));
	4'h1, 4'h3: mode = oddRow ? IzY : IzX;
	4'h2: mode = (oddRow || !ins[7]) ? Imp : Imm;
	4'h4, 4'h5: mode = oddRow ? ZpX : Zp;
	4'h6, 4'h7: mode = oddRow ? (yIndexed ? ZpY : ZpX) : Zp;
	4'h8, 4'hA: mode = Imp;
	4'h9, 4'hB: mode = oddRow ? AbY : Imm;
	4'hC: mode = oddRow ? AbX : ((ins == 8'h6C) ? Ind : Abs);
	4'hD: mode = oddRow ? AbX : Abs;
	4'hE, 4'hF: mode = oddRow ? (yIndexed ? AbY : AbX) : Abs;
	default: mode = Imp;
	endcase
end

always_comb
begin
	case (mode)
	Imp: pc_bytes = 2'd1;
	Ind, Abs, AbX, AbY: pc_bytes = 2'd3;
	default: pc_bytes = 2'd2;   // one operand byte
	endcase
end

endmodule

//--- hdl/fetchUnit.sv
`timescale 1ns/1ps
`include "opStream_defines.svh"

module fetchUnit import typepkg::*;
(
	input logic clk,
	input logic arstN,
	input logic start,
	input addr_t startPc,
	output logic memRd,
	output addr_t memAddr,
	input byte_t memData,
	output logic halted,
	insBus.source ins
);

fetchState_t state;
logic opPhase;        // returning byte is an opcode
insLen_t argCnt;      // operand bytes collected so far
Opcode decOp;
Addressing decMode;
insLen_t decLen;
addr_t dataAddr;
logic takeOp;
logic takeArg;
logic insDone;

idec decoder
(
	.ins(memData),
	.opcode(decOp),
	.mode(decMode),
	.pc_bytes(decLen)
);

// one read per cycle, so the byte now on memData came from the previous address
assign dataAddr = memAddr - addr_t'(1);
assign takeOp = (state == Collect) && opPhase;
assign takeArg = (state == Collect) && !opPhase;
assign insDone = takeOp ? (decLen == insLen_t'(1))
	: (takeArg && (argCnt + insLen_t'(2) == ins.len));
assign halted = (state == Halted);

always_ff @(posedge clk or negedge arstN)
begin
	if (!arstN)
	begin
		state <= Idle;
		memRd <= 1'b0;
		memAddr <= '0;
		opPhase <= 1'b1;
		argCnt <= '0;
		ins.valid <= 1'b0;
	end
	else if (start)
	begin
		state <= Lead;   // restart, partial bytes dropped
		memRd <= 1'b1;
		memAddr <= startPc;
		opPhase <= 1'b1;
		argCnt <= '0;
		ins.valid <= 1'b0;
	end
	else
	begin
		ins.valid <= insDone;
		case (state)
		Lead:
		begin
			state <= Collect;
			memAddr <= memAddr + addr_t'(1);
		end
		Collect:
		begin
			memAddr <= memAddr + addr_t'(1);
			opPhase <= insDone;
			argCnt <= (takeArg && !insDone) ? argCnt + insLen_t'(1) : '0;
			if (takeOp && (decOp == KIL))
			begin
				state <= Halted;   // byte still in flight is ignored
				memRd <= 1'b0;
			end
		end
		default:
		begin
			state <= state;   // idle or halted until start
		end
		endcase
	end
end

always_ff @(posedge clk)
begin
	if (takeOp)
	begin
		ins.pc <= dataAddr;
		ins.opcode <= decOp;
		ins.mode <= decMode;
		ins.len <= decLen;
		ins.operand <= '0;
	end
	else if (takeArg)
	begin
		if (argCnt == '0)
			ins.operand[`DATA_W-1:0] <= memData;   // low byte first
		else
			ins.operand[`ADDR_W-1:`DATA_W] <= memData;
	end
end

// no reads once KIL has been framed
assert property (@(posedge clk) disable iff (!arstN) (state == Halted) |-> !memRd);

// back-to-back pulses must carry different instructions
assert property (@(posedge clk) disable iff (!arstN)
	ins.valid |=> (!ins.valid || (ins.pc != $past(ins.pc))));

endmodule

//--- hdl/eaCalc.sv
`timescale 1ns/1ps
`include "opStream_defines.svh"

module eaCalc import typepkg::*;
(
	input logic clk,
	input logic arstN,
	insBus.sink ins,
	input byte_t regX,
	input byte_t regY,
	output logic insValid,
	output addr_t insPc,
	output Opcode insOpcode,
	output Addressing insMode,
	output addr_t insOperand,
	output addr_t effAddr
);

byte_t zpLow;
byte_t zpPlusX;     // wraps inside page zero
byte_t zpPlusY;
addr_t nextPc;
addr_t relOffset;
addr_t eaNext;

assign zpLow = ins.operand[`DATA_W-1:0];
assign zpPlusX = zpLow + regX;
assign zpPlusY = zpLow + regY;
assign nextPc = ins.pc + addr_t'(ins.len);
assign relOffset = {{(`ADDR_W-`DATA_W){zpLow[`DATA_W-1]}}, zpLow};   // sign extend

always_comb
begin
	case (ins.mode)
	Imm: eaNext = ins.pc + addr_t'(1);   // byte after the opcode
	Zp, Abs, Ind, IzY: eaNext = ins.operand;
	ZpX, IzX: eaNext = addr_t'(zpPlusX);
	ZpY: eaNext = addr_t'(zpPlusY);
	AbX: eaNext = ins.operand + addr_t'(regX);
	AbY: eaNext = ins.operand + addr_t'(regY);
	Rel: eaNext = nextPc + relOffset;
	default: eaNext = '0;   // implied
	endcase
end

always_ff @(posedge clk or negedge arstN)
begin
	if (!arstN)
		insValid <= 1'b0;
	else
		insValid <= ins.valid;
end

always_ff @(posedge clk)
begin
	if (ins.valid)
	begin
		insPc <= ins.pc;
		insOpcode <= ins.opcode;
		insMode <= ins.mode;
		insOperand <= ins.operand;
		effAddr <= eaNext;
	end
end

// every result follows a fetch record by exactly one cycle
assert property (@(posedge clk) disable iff (!arstN) insValid == $past(ins.valid));

endmodule

//--- hdl/opStream.sv
`timescale 1ns/1ps

module opStream import typepkg::*;
(
	input logic clk,
	input logic arstN,
	input logic start,
	input addr_t startPc,
	input byte_t regX,
	input byte_t regY,
	output logic memRd,
	output addr_t memAddr,
	input byte_t memData,
	output logic insValid,
	output addr_t insPc,
	output Opcode insOpcode,
	output Addressing insMode,
	output addr_t insOperand,
	output addr_t effAddr,
	output logic halted
);

insBus insLink ();   // framed instruction, fetch to address stage

fetchUnit fetchInst
(
	.clk(clk),
	.arstN(arstN),
	.start(start),
	.startPc(startPc),
	.memRd(memRd),
	.memAddr(memAddr),
	.memData(memData),
	.halted(halted),
	.ins(insLink)
);

eaCalc eaInst
(
	.clk(clk),
	.arstN(arstN),
	.ins(insLink),
	.regX(regX),
	.regY(regY),
	.insValid(insValid),
	.insPc(insPc),
	.insOpcode(insOpcode),
	.insMode(insMode),
	.insOperand(insOperand),
	.effAddr(effAddr)
);

endmodule

//--- sim/tb_opStream.sv
`timescale 1ns/1ps
`include "opStream_defines.svh"

module tb_opStream import typepkg::*; ();

localparam int stepDelay = 5;     // input drive delay after the rising edge
localparam int waitLimit = 40;    // cycles allowed per expected record
localparam int haltCycles = 10;
localparam int kilCode = 36;      // KIL position in the mnemonic list

logic clk = 1'b0;
logic arstN;
logic start;
addr_t startPc;
byte_t regX;
byte_t regY;
byte_t memData;
logic memRd;
addr_t memAddr;
logic insValid;
addr_t insPc;
Opcode insOpcode;
Addressing insMode;
addr_t insOperand;
addr_t effAddr;
logic halted;

byte_t mem [0:65535];   // 64 KiB program memory
logic rdEn = 1'b0;
addr_t rdAddr;
int fd;
int recCount;
logic havePrev;       // a record of this run was already seen
logic [`TRACE_W-1:0] prevPc;
int prevMode;

opStream dut_i
(
	.clk(clk),
	.arstN(arstN),
	.start(start),
	.startPc(startPc),
	.regX(regX),
	.regY(regY),
	.memRd(memRd),
	.memAddr(memAddr),
	.memData(memData),
	.insValid(insValid),
	.insPc(insPc),
	.insOpcode(insOpcode),
	.insMode(insMode),
	.insOperand(insOperand),
	.effAddr(effAddr),
	.halted(halted)
);

always #50 clk = ~clk;

// read issued in one cycle, data shows up in the next
always @(negedge clk)
begin
	rdEn <= memRd;
	rdAddr <= memAddr;
end

always @(posedge clk)
begin
	#stepDelay;
	if (rdEn)
		memData = mem[rdAddr];
end

task automatic abortRun(input string reason);
	$display("%s", reason);
	$display("Test failures found");
	$fatal(1);
endtask

task automatic check(input string name, input logic [`TRACE_W-1:0] expected,
	input logic [`TRACE_W-1:0] actual);
	if (expected !== actual)
		abortRun($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
endtask

task automatic afterEdge;
	@(posedge clk);
	#stepDelay;
endtask

// instruction length implied by the addressing mode code
function automatic int lenOfMode(input int mode);
	case (mode)
	0: return 1;             // implied
	2, 8, 9, 10: return 3;   // ind, abs, abs x, abs y
	default: return 2;
	endcase
endfunction

task automatic checkIdle(input int cycles);
	int i;
	for (i = 0; i < cycles; i++)
	begin
		@(negedge clk);
		check("idle memRd", 0, memRd);
		check("idle insValid", 0, insValid);
		check("idle halted", 0, halted);
	end
endtask

task automatic waitResult(input int recNum);
	int n;
	logic seen;
	n = 0;
	seen = 1'b0;
	while (!seen && n < waitLimit)
	begin
		@(negedge clk);
		seen = (insValid === 1'b1);
		n++;
	end
	if (!seen)
		abortRun($sformatf("no result within %0d cycles for record %0d", waitLimit, recNum));
endtask

task automatic checkHalt(input string tag);
	int i;
	for (i = 0; i < haltCycles; i++)
	begin
		check($sformatf("%s halted", tag), 1, halted);
		check($sformatf("%s memRd", tag), 0, memRd);
		@(negedge clk);
	end
endtask

task automatic loadBytes;
	logic [`TRACE_W-1:0] addr;
	logic [`TRACE_W-1:0] value;
	int count;
	int i;
	int rc;
	rc = $fscanf(fd, "%h %d", addr, count);
	if (rc != 2)
		abortRun("malformed M record in trace");
	for (i = 0; i < count; i++)
	begin
		rc = $fscanf(fd, "%h", value);
		if (rc != 1)
			abortRun("M record in trace is missing bytes");
		mem[addr[`ADDR_W-1:0] + addr_t'(i)] = value[`DATA_W-1:0];
	end
endtask

task automatic setRegs;
	logic [`TRACE_W-1:0] x;
	logic [`TRACE_W-1:0] y;
	int rc;
	rc = $fscanf(fd, "%h %h", x, y);
	if (rc != 2)
		abortRun("malformed R record in trace");
	afterEdge();
	regX = x[`DATA_W-1:0];
	regY = y[`DATA_W-1:0];
endtask

task automatic startRun;
	logic [`TRACE_W-1:0] pc;
	int rc;
	rc = $fscanf(fd, "%h", pc);
	if (rc != 1)
		abortRun("malformed S record in trace");
	afterEdge();
	start = 1'b1;
	startPc = pc[`ADDR_W-1:0];
	afterEdge();
	start = 1'b0;
	@(negedge clk);
	check("start halted", 0, halted);   // halt clears on the strobe
	check("start memRd", 1, memRd);
	check("start memAddr", pc, memAddr);   // first read at the start address
	havePrev = 1'b0;
endtask

task automatic checkRecord;
	logic [`TRACE_W-1:0] expPc;
	logic [`TRACE_W-1:0] expOp;
	logic [`TRACE_W-1:0] expMode;
	logic [`TRACE_W-1:0] expOperand;
	logic [`TRACE_W-1:0] expEa;
	string tag;
	int rc;
	rc = $fscanf(fd, "%h %d %d %h %h", expPc, expOp, expMode, expOperand, expEa);
	if (rc != 5)
		abortRun("malformed E record in trace");
	recCount++;
	tag = $sformatf("record %0d", recCount);
	waitResult(recCount);
	check($sformatf("%s pc", tag), expPc, insPc);
	check($sformatf("%s opcode", tag), expOp, insOpcode);
	check($sformatf("%s mode", tag), expMode, insMode);
	check($sformatf("%s operand", tag), expOperand, insOperand);
	check($sformatf("%s effAddr", tag), expEa, effAddr);
	if (havePrev)
		check($sformatf("%s pc step", tag), prevPc + lenOfMode(prevMode), insPc);
	prevPc = expPc;
	prevMode = expMode;
	havePrev = 1'b1;
	if (expOp == kilCode)
		checkHalt(tag);
endtask

initial
begin
	int i;
	int rc;
	logic done;
	logic [7:0] kind;
	logic [8*160-1:0] lineBuf;
	for (i = 0; i < 65536; i++)
		mem[i] = i[15:8] ^ i[7:0] ^ 8'h5a;   // pattern over the whole address
	arstN = 1'b0;
	start = 1'b0;
	startPc = '0;
	regX = '0;
	regY = '0;
	memData = '0;
	recCount = 0;
	havePrev = 1'b0;
	prevPc = '0;
	prevMode = 0;
	repeat (5) @(posedge clk);
	#stepDelay;
	arstN = 1'b1;
	checkIdle(4);
	fd = $fopen("sim/opStream_trace.txt", "r");
	if (fd == 0)
		abortRun("cannot open sim/opStream_trace.txt");
	done = 1'b0;
	while (!done)
	begin
		rc = $fscanf(fd, " %c", kind);
		if (rc != 1)
			done = 1'b1;
		else
		begin
			case (kind)
			"#": rc = $fgets(lineBuf, fd);   // comment line
			"M": loadBytes();
			"R": setRegs();
			"S": startRun();
			"E": checkRecord();
			default: abortRun($sformatf("unknown record kind %c in trace", kind));
			endcase
		end
	end
	$fclose(fd);
	if (recCount == 0)
		abortRun("trace holds no expected records");
	else
	begin
		$display("All tests passed!");
		$finish;
	end
end

endmodule

//--- opStream.f
+incdir+hdl
hdl/typepkg.sv
hdl/insBus.sv
hdl/idec.sv
hdl/fetchUnit.sv
hdl/eaCalc.sv
hdl/opStream.sv
sim/tb_opStream.sv

//--- sim/opStream_trace.txt
# M addr count bytes | R regX regY | S startPc
# E pc opcode mode operand effAddr, with opcode and mode as decimal enum codes
M 0200 8 a9 42 a5 80 b5 fd b6 20
M 0208 9 ad 34 12 bd 00 30 b9 f8 40
M 0211 11 a1 fe b1 40 6c 00 03 e8 d0 f0 02
M 0400 8 96 90 9d ff 01 79 01 c0
M 0408 6 10 80 81 9f ea 12
# first run covers every addressing mode
R 05 10
S 0200
E 0200 39 1 0042 0201
E 0202 39 5 0080 0080
E 0204 39 6 00fd 0002
E 0206 40 7 0020 0030
E 0208 39 8 1234 1234
E 020b 39 9 3000 3005
E 020e 39 10 40f8 4108
E 0211 39 3 00fe 0003
E 0213 39 4 0040 0040
E 0215 34 2 0300 0300
E 0218 31 0 0000 0000
E 0219 13 11 00f0 020b
E 021b 36 0 0000 0000
# second run restarts from halt with new index registers
R 80 ff
S 0400
E 0400 65 7 0090 008f
E 0402 64 9 01ff 027f
E 0405 0 10 c001 c100
E 0408 14 11 0080 038a
E 040a 64 3 009f 001f
E 040c 43 0 0000 0000
E 040d 36 0 0000 0000
